//--- hdl/ppu_reg_pkg.sv
package ppu_reg_pkg;

    // CPU-visible register offsets
    typedef enum logic [2:0] {
        PPUCTRL   = 3'd0,
        PPUMASK   = 3'd1,
        PPUSTATUS = 3'd2,
        OAMADDR   = 3'd3,
        OAMDATA   = 3'd4,
        PPUSCROLL = 3'd5,
        PPUADDR   = 3'd6,
        PPUDATA   = 3'd7
    } reg_t;

    // nametable mirroring as set by the cartridge
    typedef enum logic {
        MIRROR_HORIZONTAL = 1'b0,
        MIRROR_VERTICAL   = 1'b1
    } mirror_t;

    // target of a PPUDATA access
    typedef enum logic [1:0] {
        REGION_NONE = 2'd0,
        REGION_NT   = 2'd1,
        REGION_PAL  = 2'd2
    } region_t;

    // loopy layout: fine Y 14..12, nametable 11..10, coarse Y 9..5, coarse X 4..0
    typedef logic [14:0] vaddr_t;

    localparam int FINE_X_W   = 3;
    localparam int NT_ADDR_W  = 11;
    localparam int PAL_ADDR_W = 5;
    localparam int OAM_ADDR_W = 8;

    // region starts in the 14-bit PPU address space
    localparam logic [13:0] NT_BASE  = 14'h2000;
    localparam logic [13:0] PAL_BASE = 14'h3F00;

    localparam int CTRL_INC_BIT = 2;

    localparam vaddr_t INC_ACROSS = 15'd1;
    localparam vaddr_t INC_DOWN   = 15'd32;

endpackage

//--- hdl/vram_route.sv
module vram_route (
    input  ppu_reg_pkg::vaddr_t                 v,
    input  ppu_reg_pkg::mirror_t                mirroring,
    output logic [ppu_reg_pkg::NT_ADDR_W-1:0]   nt_addr,
    output logic [ppu_reg_pkg::PAL_ADDR_W-1:0]  pal_addr,
    output ppu_reg_pkg::region_t                region
);

    logic [13:0] addr;
    logic        nt_bank;

    // fine Y bit 14 is outside the bus
    assign addr = v[13:0];

    // CHR space below the nametables is not handled here
    always_comb begin
        if (addr < ppu_reg_pkg::NT_BASE) begin
            region = ppu_reg_pkg::REGION_NONE;
        end else if (addr < ppu_reg_pkg::PAL_BASE) begin
            region = ppu_reg_pkg::REGION_NT;
        end else begin
            region = ppu_reg_pkg::REGION_PAL;
        end
    end

    // horizontal: 2000/2400 share a bank, 2800/2C00 the other
    always_comb begin
        if (mirroring == ppu_reg_pkg::MIRROR_HORIZONTAL) begin
            nt_bank = addr[11];
        end else begin
            nt_bank = addr[10];
        end
    end

    // 3000-3EFF folds onto 2000-2EFF through the dropped bit 12
    assign nt_addr = {nt_bank, addr[9:0]};

    // sprite backdrop entries share the background ones
    always_comb begin
        if (addr[4] && addr[1:0] == 2'b00) begin
            pal_addr = {1'b0, addr[3:0]};
        end else begin
            pal_addr = addr[4:0];
        end
    end

endmodule

//--- hdl/status_flags.sv
module status_flags (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sp_over_set,
    input  logic       sp_over_clr,
    input  logic       sp_zero_set,
    input  logic       sp_zero_clr,
    input  logic       vblank_set,
    input  logic       vblank_clr,
    input  logic       status_rd,
    input  logic       last_write_load,
    input  logic [7:0] last_write_data,
    output logic [7:0] status
);

    logic       vblank;
    logic       sp_zero;
    logic       sp_over;
    logic [4:0] last_write;

    // clear takes priority over set in every flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vblank     <= 1'b0;
            sp_zero    <= 1'b0;
            sp_over    <= 1'b0;
            last_write <= 5'd0;
        end else begin
            if (vblank_clr || status_rd) begin
                vblank <= 1'b0;
            end else if (vblank_set) begin
                vblank <= 1'b1;
            end
            if (sp_zero_clr) begin
                sp_zero <= 1'b0;
            end else if (sp_zero_set) begin
                sp_zero <= 1'b1;
            end
            if (sp_over_clr) begin
                sp_over <= 1'b0;
            end else if (sp_over_set) begin
                sp_over <= 1'b1;
            end
            // low bits read back as open bus
            if (last_write_load) begin
                last_write <= last_write_data[4:0];
            end
        end
    end

    assign status = {vblank, sp_zero, sp_over, last_write};

    // colliding pulses must leave the flag low
    assert property (@(posedge clk) disable iff (!rst_n)
        (vblank_set && (vblank_clr || status_rd)) |=> !status[7]);
    assert property (@(posedge clk) disable iff (!rst_n)
        (sp_zero_set && sp_zero_clr) |=> !status[6]);
    assert property (@(posedge clk) disable iff (!rst_n)
        (sp_over_set && sp_over_clr) |=> !status[5]);

endmodule

//--- hdl/loopy_regs.sv
module loopy_regs (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              v_load,
    input  ppu_reg_pkg::vaddr_t               v_next,
    input  logic                              t_load,
    input  ppu_reg_pkg::vaddr_t               t_next,
    input  logic                              fine_x_load,
    input  logic [ppu_reg_pkg::FINE_X_W-1:0]  fine_x_next,
    output ppu_reg_pkg::vaddr_t               v,
    output ppu_reg_pkg::vaddr_t               t,
    output logic [ppu_reg_pkg::FINE_X_W-1:0]  fine_x
);

    // current VRAM address, also the scroll position during rendering
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v <= '0;
        end else if (v_load) begin
            v <= v_next;
        end
    end

    // temporary address, staged by the CPU writes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t <= '0;
        end else if (t_load) begin
            t <= t_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fine_x <= '0;
        end else if (fine_x_load) begin
            fine_x <= fine_x_next;
        end
    end

    // copy of t into v after a high byte with bit 14 low leaves both clear
    assert property (@(posedge clk) disable iff (!rst_n)
        (v_load && t_load && !t[14]) |=> (!v[14] && !t[14]));

endmodule

//--- hdl/ppu_reg_decode.sv
module ppu_reg_decode (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    reg_en,
    input  logic                                    reg_rw,
    input  ppu_reg_pkg::reg_t                       reg_sel,
    input  logic [7:0]                              reg_data_in,
    output logic [7:0]                              reg_data_out,
    output logic [7:0]                              ppuctrl,
    output logic [7:0]                              ppumask,
    output logic [ppu_reg_pkg::OAM_ADDR_W-1:0]      oam_addr,
    output logic                                    oam_we,
    output logic                                    oam_re,
    output logic [7:0]                              oam_wr_data,
    input  logic [7:0]                              oam_rd_data,
    input  ppu_reg_pkg::vaddr_t                     v,
    input  ppu_reg_pkg::vaddr_t                     t,
    output logic                                    v_load,
    output ppu_reg_pkg::vaddr_t                     v_next,
    output logic                                    t_load,
    output ppu_reg_pkg::vaddr_t                     t_next,
    output logic                                    fine_x_load,
    output logic [ppu_reg_pkg::FINE_X_W-1:0]        fine_x_next,
    input  ppu_reg_pkg::region_t                    region,
    output logic                                    nt_we,
    output logic                                    nt_re,
    output logic                                    pal_we,
    output logic                                    pal_re,
    output logic [7:0]                              nt_wr_data,
    output logic [7:0]                              pal_wr_data,
    input  logic [7:0]                              nt_rd_data,
    input  logic [7:0]                              pal_rd_data,
    input  logic [7:0]                              status,
    output logic                                    status_rd,
    output logic                                    last_write_load,
    output logic [7:0]                              last_write_data
);

    logic                wr_en;
    logic                rd_en;
    // 0 while waiting for the first of a write pair
    logic                toggle;
    logic                toggle_flip;
    logic [7:0]          read_buf;
    logic                buf_load;
    logic [7:0]          rd_next;
    ppu_reg_pkg::vaddr_t v_step;

    assign wr_en = reg_en && reg_rw;
    assign rd_en = reg_en && !reg_rw;

    assign v_step = ppuctrl[ppu_reg_pkg::CTRL_INC_BIT] ? ppu_reg_pkg::INC_DOWN
                                                        : ppu_reg_pkg::INC_ACROSS;

    // write data goes straight to every target, strobes pick the one
    assign oam_wr_data     = reg_data_in;
    assign nt_wr_data      = reg_data_in;
    assign pal_wr_data     = reg_data_in;
    assign last_write_load = wr_en;
    assign last_write_data = reg_data_in;

    always_comb begin
        v_load      = 1'b0;
        v_next      = v + v_step;
        t_load      = 1'b0;
        t_next      = t;
        fine_x_load = 1'b0;
        fine_x_next = reg_data_in[2:0];
        oam_we      = 1'b0;
        oam_re      = 1'b0;
        nt_we       = 1'b0;
        nt_re       = 1'b0;
        pal_we      = 1'b0;
        pal_re      = 1'b0;
        status_rd   = 1'b0;
        toggle_flip = 1'b0;
        buf_load    = 1'b0;
        rd_next     = reg_data_out;
        case (reg_sel)
            ppu_reg_pkg::PPUCTRL: begin
                if (wr_en) begin
                    t_load        = 1'b1;
                    t_next[11:10] = reg_data_in[1:0];
                end
            end
            ppu_reg_pkg::PPUSTATUS: begin
                if (rd_en) begin
                    status_rd = 1'b1;
                    rd_next   = status;
                end
            end
            ppu_reg_pkg::OAMDATA: begin
                oam_we = wr_en;
                oam_re = rd_en;
                if (rd_en) begin
                    rd_next = oam_rd_data;
                end
            end
            ppu_reg_pkg::PPUSCROLL: begin
                if (wr_en) begin
                    toggle_flip = 1'b1;
                    t_load      = 1'b1;
                    if (!toggle) begin
                        // X scroll: coarse into t, fine into fine_x
                        fine_x_load = 1'b1;
                        t_next[4:0] = reg_data_in[7:3];
                    end else begin
                        t_next[14:12] = reg_data_in[2:0];
                        t_next[9:5]   = reg_data_in[7:3];
                    end
                end
            end
            ppu_reg_pkg::PPUADDR: begin
                if (wr_en) begin
                    toggle_flip = 1'b1;
                    t_load      = 1'b1;
                    if (!toggle) begin
                        // high byte, top bit of t forced low
                        t_next[14:8] = {1'b0, reg_data_in[5:0]};
                    end else begin
                        t_next[7:0] = reg_data_in;
                        v_load      = 1'b1;
                        v_next      = {t[14:8], reg_data_in};
                    end
                end
            end
            ppu_reg_pkg::PPUDATA: begin
                v_load = reg_en;
                if (wr_en) begin
                    nt_we  = (region == ppu_reg_pkg::REGION_NT);
                    pal_we = (region == ppu_reg_pkg::REGION_PAL);
                end else if (rd_en) begin
                    if (region == ppu_reg_pkg::REGION_NT) begin
                        // stale byte out, buffer refilled
                        nt_re    = 1'b1;
                        buf_load = 1'b1;
                        rd_next  = read_buf;
                    end else if (region == ppu_reg_pkg::REGION_PAL) begin
                        pal_re  = 1'b1;
                        rd_next = pal_rd_data;
                    end
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ppuctrl      <= 8'd0;
            ppumask      <= 8'd0;
            oam_addr     <= '0;
            toggle       <= 1'b0;
            read_buf     <= 8'd0;
            reg_data_out <= 8'd0;
        end else begin
            if (wr_en && reg_sel == ppu_reg_pkg::PPUCTRL) begin
                ppuctrl <= reg_data_in;
            end
            if (wr_en && reg_sel == ppu_reg_pkg::PPUMASK) begin
                ppumask <= reg_data_in;
            end
            if (wr_en && reg_sel == ppu_reg_pkg::OAMADDR) begin
                oam_addr <= reg_data_in;
            end else if (oam_we) begin
                oam_addr <= oam_addr + 1'b1;
            end
            // status read wins over a pending pair
            if (status_rd) begin
                toggle <= 1'b0;
            end else if (toggle_flip) begin
                toggle <= ~toggle;
            end
            if (buf_load) begin
                read_buf <= nt_rd_data;
            end
            if (rd_en) begin
                reg_data_out <= rd_next;
            end
        end
    end

    // routed region never yields two write targets
    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({nt_we, pal_we, oam_we}));

endmodule

//--- hdl/ppu_reg_top.sv
module ppu_reg_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                reg_en,
    input  logic                                reg_rw,
    input  ppu_reg_pkg::reg_t                   reg_sel,
    input  logic [7:0]                          reg_data_in,
    output logic [7:0]                          reg_data_out,
    input  logic                                sp_over_set,
    input  logic                                sp_over_clr,
    input  logic                                sp_zero_set,
    input  logic                                sp_zero_clr,
    input  logic                                vblank_set,
    input  logic                                vblank_clr,
    input  ppu_reg_pkg::mirror_t                mirroring,
    output logic [ppu_reg_pkg::OAM_ADDR_W-1:0]  oam_addr,
    output logic                                oam_we,
    output logic                                oam_re,
    output logic [7:0]                          oam_wr_data,
    input  logic [7:0]                          oam_rd_data,
    output logic [ppu_reg_pkg::NT_ADDR_W-1:0]   vram_addr,
    output logic                                vram_we,
    output logic                                vram_re,
    output logic [7:0]                          vram_wr_data,
    input  logic [7:0]                          vram_rd_data,
    output logic [ppu_reg_pkg::PAL_ADDR_W-1:0]  pal_addr,
    output logic                                pal_we,
    output logic                                pal_re,
    output logic [7:0]                          pal_wr_data,
    input  logic [7:0]                          pal_rd_data,
    output logic [7:0]                          ppuctrl,
    output logic [7:0]                          ppumask,
    output ppu_reg_pkg::vaddr_t                 v_addr,
    output logic [ppu_reg_pkg::FINE_X_W-1:0]    fine_x
);

    ppu_reg_pkg::vaddr_t              t;
    logic                             v_load;
    ppu_reg_pkg::vaddr_t              v_next;
    logic                             t_load;
    ppu_reg_pkg::vaddr_t              t_next;
    logic                             fine_x_load;
    logic [ppu_reg_pkg::FINE_X_W-1:0] fine_x_next;
    ppu_reg_pkg::region_t             region;
    logic [7:0]                       status;
    logic                             status_rd;
    logic                             last_write_load;
    logic [7:0]                       last_write_data;

    ppu_reg_decode u_decode (
        .clk, .rst_n, .reg_en, .reg_rw, .reg_sel, .reg_data_in, .reg_data_out,
        .ppuctrl, .ppumask,
        .oam_addr, .oam_we, .oam_re, .oam_wr_data, .oam_rd_data,
        .v(v_addr), .t, .v_load, .v_next, .t_load, .t_next, .fine_x_load, .fine_x_next,
        .region,
        .nt_we(vram_we), .nt_re(vram_re), .pal_we, .pal_re,
        .nt_wr_data(vram_wr_data), .pal_wr_data,
        .nt_rd_data(vram_rd_data), .pal_rd_data,
        .status, .status_rd, .last_write_load, .last_write_data
    );

    loopy_regs u_loopy (
        .clk, .rst_n,
        .v_load, .v_next, .t_load, .t_next, .fine_x_load, .fine_x_next,
        .v(v_addr), .t, .fine_x
    );

    status_flags u_status (
        .clk, .rst_n,
        .sp_over_set, .sp_over_clr, .sp_zero_set, .sp_zero_clr,
        .vblank_set, .vblank_clr,
        .status_rd, .last_write_load, .last_write_data, .status
    );

    vram_route u_route (
        .v(v_addr), .mirroring,
        .nt_addr(vram_addr), .pal_addr, .region
    );

endmodule

//--- tb/ppu_reg_tb.sv
module ppu_reg_tb;

    localparam int EDGE_LIMIT = 40;

    logic                                clk;
    logic                                rst_n;
    logic                                reg_en;
    logic                                reg_rw;
    ppu_reg_pkg::reg_t                   reg_sel;
    logic [7:0]                          reg_data_in;
    logic [7:0]                          reg_data_out;
    logic                                sp_over_set;
    logic                                sp_over_clr;
    logic                                sp_zero_set;
    logic                                sp_zero_clr;
    logic                                vblank_set;
    logic                                vblank_clr;
    ppu_reg_pkg::mirror_t                mirroring;
    logic [ppu_reg_pkg::OAM_ADDR_W-1:0]  oam_addr;
    logic                                oam_we;
    logic                                oam_re;
    logic [7:0]                          oam_wr_data;
    logic [7:0]                          oam_rd_data;
    logic [ppu_reg_pkg::NT_ADDR_W-1:0]   vram_addr;
    logic                                vram_we;
    logic                                vram_re;
    logic [7:0]                          vram_wr_data;
    logic [7:0]                          vram_rd_data;
    logic [ppu_reg_pkg::PAL_ADDR_W-1:0]  pal_addr;
    logic                                pal_we;
    logic                                pal_re;
    logic [7:0]                          pal_wr_data;
    logic [7:0]                          pal_rd_data;
    logic [7:0]                          ppuctrl;
    logic [7:0]                          ppumask;
    ppu_reg_pkg::vaddr_t                 v_addr;
    logic [ppu_reg_pkg::FINE_X_W-1:0]    fine_x;

    // RAM models behind the DUT
    logic [7:0] nt_mem  [0:2047];
    logic [7:0] pal_mem [0:31];
    logic [7:0] oam_mem [0:255];

    int  edge_count = 0;
    time last_edge  = 0;
    bit  timed_out  = 1'b0;
    bit  file_error = 1'b0;
    int  total_tests  = 0;
    int  total_checks = 0;
    int  total_errors = 0;
    int  test_checks  = 0;
    int  test_errors  = 0;

    ppu_reg_top dut0 (
        .clk, .rst_n, .reg_en, .reg_rw, .reg_sel, .reg_data_in, .reg_data_out,
        .sp_over_set, .sp_over_clr, .sp_zero_set, .sp_zero_clr,
        .vblank_set, .vblank_clr, .mirroring,
        .oam_addr, .oam_we, .oam_re, .oam_wr_data, .oam_rd_data,
        .vram_addr, .vram_we, .vram_re, .vram_wr_data, .vram_rd_data,
        .pal_addr, .pal_we, .pal_re, .pal_wr_data, .pal_rd_data,
        .ppuctrl, .ppumask, .v_addr, .fine_x
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        edge_count = edge_count + 1;
        last_edge  = $time;
    end

    // async reads only while the read strobe is high
    assign vram_rd_data = vram_re ? nt_mem[vram_addr] : 8'hxx;
    assign pal_rd_data  = pal_re ? pal_mem[pal_addr] : 8'hxx;
    assign oam_rd_data  = oam_re ? oam_mem[oam_addr] : 8'hxx;

    // writes on the DUT strobes, cleared while in reset
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2048; i++) begin
                nt_mem[i] <= 8'd0;
            end
            for (int i = 0; i < 32; i++) begin
                pal_mem[i] <= 8'd0;
            end
            for (int i = 0; i < 256; i++) begin
                oam_mem[i] <= 8'd0;
            end
        end else begin
            if (vram_we) begin
                nt_mem[vram_addr] <= vram_wr_data;
            end
            if (pal_we) begin
                pal_mem[pal_addr] <= pal_wr_data;
            end
            if (oam_we) begin
                oam_mem[oam_addr] <= oam_wr_data;
            end
        end
    end

    // returns one unit after the next rising edge
    task automatic wait_edge();
        int waited;
        int start;
        waited = 0;
        start  = edge_count;
        while (edge_count == start && waited < EDGE_LIMIT) begin
            #1;
            waited++;
        end
        if (edge_count == start) begin
            $display("timeout: no rising clock edge within %0d time units", EDGE_LIMIT);
            timed_out = 1'b1;
        end else if ($time == last_edge) begin
            #1;
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        test_checks++;
        if (got !== expected) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, expected);
            test_errors++;
        end
    endtask

    task automatic clear_flags();
        sp_over_set = 1'b0;
        sp_over_clr = 1'b0;
        sp_zero_set = 1'b0;
        sp_zero_clr = 1'b0;
        vblank_set  = 1'b0;
        vblank_clr  = 1'b0;
    endtask

    task automatic pulse_flag(input logic [2:0] flag);
        case (flag)
            3'd0: vblank_set = 1'b1;
            3'd1: vblank_clr = 1'b1;
            3'd2: sp_zero_set = 1'b1;
            3'd3: sp_zero_clr = 1'b1;
            3'd4: sp_over_set = 1'b1;
            3'd5: sp_over_clr = 1'b1;
            default: begin
                $display("unknown flag number %0d in the stimulus file", flag);
                test_errors++;
            end
        endcase
        wait_edge();
        clear_flags();
    endtask

    task automatic check_port(input logic [2:0] port, input logic [15:0] expected);
        case (port)
            3'd0: check_value("ppuctrl", {8'd0, ppuctrl}, expected);
            3'd1: check_value("ppumask", {8'd0, ppumask}, expected);
            3'd2: check_value("v_addr", {1'b0, v_addr}, expected);
            3'd3: check_value("fine_x", {13'd0, fine_x}, expected);
            3'd4: check_value("oam_addr", {8'd0, oam_addr}, expected);
            default: begin
                $display("unknown port number %0d in the stimulus file", port);
                test_errors++;
            end
        endcase
    endtask

    task automatic run_command(input logic [7:0] cmd, input logic [15:0] arg,
                               input logic [15:0] value);
        if (cmd == "w") begin
            reg_en      = 1'b1;
            reg_rw      = 1'b1;
            reg_sel     = ppu_reg_pkg::reg_t'(arg[2:0]);
            reg_data_in = value[7:0];
            wait_edge();
            reg_en = 1'b0;
            reg_rw = 1'b0;
        end else if (cmd == "r") begin
            reg_en  = 1'b1;
            reg_rw  = 1'b0;
            reg_sel = ppu_reg_pkg::reg_t'(arg[2:0]);
            wait_edge();
            reg_en = 1'b0;
            check_value("reg_data_out", {8'd0, reg_data_out}, value);
        end else if (cmd == "p") begin
            pulse_flag(arg[2:0]);
        end else if (cmd == "m") begin
            mirroring = ppu_reg_pkg::mirror_t'(arg[0]);
            wait_edge();
        end else if (cmd == "c") begin
            check_port(arg[2:0], value);
        end else begin
            $display("unknown command in the stimulus file");
            test_errors++;
        end
    endtask

    task automatic close_test(input int num);
        if (test_errors == 0) begin
            $display("test %0d: ok, %0d checks", num, test_checks);
        end else begin
            $display("test %0d: FAILED, %0d checks, %0d errors", num, test_checks,
                     test_errors);
        end
        total_tests++;
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        int          fd;
        int          n;
        int          i;
        int          tnum;
        int          cur_test;
        string       line;
        logic [7:0]  cmd;
        logic [15:0] arg_a;
        logic [15:0] arg_b;
        rst_n       = 1'b0;
        reg_en      = 1'b0;
        reg_rw      = 1'b0;
        reg_sel     = ppu_reg_pkg::PPUCTRL;
        reg_data_in = 8'd0;
        mirroring   = ppu_reg_pkg::MIRROR_HORIZONTAL;
        clear_flags();
        for (i = 0; i < 16 && !timed_out; i++) begin
            wait_edge();
        end
        rst_n = 1'b1;
        fd = $fopen("tb/ppu_reg_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tb/ppu_reg_input.txt");
            file_error = 1'b1;
        end else begin
            cur_test = -1;
            while (!$feof(fd) && !timed_out) begin
                n = $fgets(line, fd);
                // comment and blank lines fail the scan
                if (n > 0 && $sscanf(line, "%d %s %h %h", tnum, cmd, arg_a, arg_b) == 4) begin
                    if (tnum != cur_test) begin
                        if (cur_test >= 0) begin
                            close_test(cur_test);
                        end
                        cur_test = tnum;
                    end
                    run_command(cmd, arg_a, arg_b);
                end
            end
            if (cur_test >= 0) begin
                close_test(cur_test);
            end
            $fclose(fd);
        end
        $display("%0d tests, %0d checks, %0d errors", total_tests, total_checks,
                 total_errors);
        if (total_errors == 0 && total_tests > 0 && !timed_out && !file_error) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- tb/ppu_reg_input.txt
# columns: test  command  arg  value, arg and value in hex
# w reg data, r reg expected, p flag 0, m mode 0, c port expected
1 w 0 81
1 w 1 1e
1 c 0 81
1 c 1 1e
1 w 0 00
1 c 0 00
2 m 0 0
2 w 6 24
2 w 6 05
2 c 2 2405
2 w 7 11
2 w 7 22
2 c 2 2407
2 w 0 04
2 w 7 33
2 c 2 2427
2 w 0 00
2 w 6 20
2 w 6 05
2 r 7 00
2 r 7 11
2 r 7 22
2 m 1 0
2 w 6 28
2 w 6 05
2 r 7 33
2 r 7 11
2 w 6 2c
2 w 6 0a
2 w 7 55
2 w 6 24
2 w 6 0a
2 r 7 22
2 r 7 55
3 w 6 20
3 w 6 30
3 w 7 66
3 w 7 77
3 w 6 20
3 w 6 30
3 r 7 00
3 r 7 66
3 r 7 77
3 w 6 3f
3 w 6 00
3 w 7 0f
3 w 6 3f
3 w 6 10
3 r 7 0f
4 w 5 7d
4 c 3 5
4 w 5 5e
4 c 3 5
4 w 6 21
4 w 6 40
4 c 2 2140
5 w 1 1b
5 p 0 0
5 r 2 9b
5 r 2 1b
5 w 6 23
5 r 2 03
5 w 6 25
5 w 6 60
5 c 2 2560
5 p 2 0
5 p 4 0
5 r 2 60
5 p 3 0
5 r 2 20
5 p 5 0
5 p 0 0
5 p 1 0
5 r 2 00
6 w 3 10
6 c 4 10
6 w 4 a1
6 w 4 b2
6 c 4 12
6 w 3 10
6 r 4 a1
6 c 4 10
6 w 3 11
6 r 4 b2
6 c 4 11

//--- ppu_reg_top.f
hdl/ppu_reg_pkg.sv
hdl/vram_route.sv
hdl/status_flags.sv
hdl/loopy_regs.sv
hdl/ppu_reg_decode.sv
hdl/ppu_reg_top.sv
tb/ppu_reg_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ppu_reg_tb \
    -f ppu_reg_top.f -o ppu_reg_sim
./obj_dir/ppu_reg_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
